// ==== source/mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// byte address and data word widths
`define MEM_ADDR_WIDTH 32
`define MEM_DATA_WIDTH 32

// word-address bits of the sram, 1024 words
`define SRAM_ADDR_BITS 10

// sram window starts at the bank-1 decode point, address bit 16
`define SRAM_BASE 32'h0001_0000

// request queue entries, also the producer's starting credit count
`define REQ_QUEUE_DEPTH 4

`endif

// ==== source/mem_pkg.sv ====
`include "mem_settings.svh"

package mem_pkg;

    // single-beat request toward the sram bank
    typedef struct packed {
        logic [`MEM_ADDR_WIDTH-1:0]   addr;
        logic                         write;
        logic [`MEM_DATA_WIDTH/8-1:0] strb;
        logic [`MEM_DATA_WIDTH-1:0]   wdata;
        // outside the sram window or not word aligned
        logic                         bad;
    } mem_req_t;

    // response, one per request, in request order
    typedef struct packed {
        // zero for writes and for bad requests
        logic [`MEM_DATA_WIDTH-1:0] rdata;
        logic                       err;
    } mem_rsp_t;

endpackage

// ==== source/mem_req_port.sv ====
`timescale 1ns/1ns
`include "mem_settings.svh"

module mem_req_port (
    input  logic               clk,
    input  logic               reset,

    // external request side
    input  logic               req_valid,
    input  mem_pkg::mem_req_t  req,
    output logic               req_ready,

    // toward the request queue
    output logic               push,
    output mem_pkg::mem_req_t  push_req,

    // from the sram bank, one per pop
    input  logic               credit_return
);

localparam int CREDIT_W    = $clog2(`REQ_QUEUE_DEPTH + 1);
localparam int OFFSET_BITS = $clog2(`MEM_DATA_WIDTH / 8);

localparam logic [`MEM_ADDR_WIDTH-1:0] WIN_BASE = `SRAM_BASE;
localparam logic [`MEM_ADDR_WIDTH-1:0] WIN_SIZE =
    (`MEM_DATA_WIDTH / 8) * (1 << `SRAM_ADDR_BITS);

logic [CREDIT_W-1:0]        credits;
logic [`MEM_ADDR_WIDTH-1:0] win_offset;
logic                       in_window;
logic                       aligned;

// one credit per free queue entry
always_ff @(posedge clk) begin
    if (reset) begin
        credits <= CREDIT_W'(`REQ_QUEUE_DEPTH);
    end
    else if (push && !credit_return) begin
        credits <= credits - 1'b1;
    end
    else if (!push && credit_return) begin
        credits <= credits + 1'b1;
    end
end

assign req_ready = (credits != '0);
assign push      = req_valid && req_ready;

// offset form avoids overflow at the top of the address space
assign win_offset = req.addr - WIN_BASE;
assign in_window  = (req.addr >= WIN_BASE) && (win_offset < WIN_SIZE);
assign aligned    = (req.addr[OFFSET_BITS-1:0] == '0);

// master's bad field is ignored, only the decode counts
always_comb begin
    push_req     = req;
    push_req.bad = !(in_window && aligned);
end

endmodule

// ==== source/mem_req_queue.sv ====
`timescale 1ns/1ns
`include "mem_settings.svh"

module mem_req_queue #(
    parameter int DEPTH = `REQ_QUEUE_DEPTH
) (
    input  logic               clk,
    input  logic               reset,

    input  logic               push,
    input  mem_pkg::mem_req_t  push_req,

    input  logic               pop,
    output logic               not_empty,
    output mem_pkg::mem_req_t  head
);

localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int COUNT_W = $clog2(DEPTH + 1);

mem_pkg::mem_req_t entries [DEPTH];

logic [PTR_W-1:0]   wr_ptr;
logic [PTR_W-1:0]   rd_ptr;
logic [COUNT_W-1:0] count;

// no full flag, the producer's credits keep pushes in bounds
always_ff @(posedge clk) begin
    if (reset) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end
    else begin
        if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        if (push && !pop) begin
            count <= count + 1'b1;
        end
        else if (!push && pop) begin
            count <= count - 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (push) begin
        entries[wr_ptr] <= push_req;
    end
end

assign not_empty = (count != '0);
assign head      = entries[rd_ptr];

endmodule

// ==== source/sram_bank.sv ====
`timescale 1ns/1ns
`include "mem_settings.svh"

module sram_bank (
    input  logic               clk,
    input  logic               reset,

    // request queue head
    input  logic               not_empty,
    input  mem_pkg::mem_req_t  head,
    output logic               pop,

    // back to the producer
    output logic               credit_return,

    // external response side
    output logic               rsp_valid,
    output mem_pkg::mem_rsp_t  rsp,
    input  logic               rsp_ready
);

localparam int SRAM_WORDS  = 1 << `SRAM_ADDR_BITS;
localparam int STRB_W      = `MEM_DATA_WIDTH / 8;
localparam int OFFSET_BITS = $clog2(STRB_W);

logic [`MEM_DATA_WIDTH-1:0] mem [SRAM_WORDS];

logic [`SRAM_ADDR_BITS-1:0] word_idx;
logic                       wr_en;
logic                       rd_en;

// word index sits just above the byte offset
assign word_idx = head.addr[OFFSET_BITS +: `SRAM_ADDR_BITS];

// take a new request only when the response slot frees up
assign pop   = not_empty && (!rsp_valid || rsp_ready);
assign wr_en = pop && head.write && !head.bad;
assign rd_en = pop && !head.write && !head.bad;

// byte lanes follow the strobes
always_ff @(posedge clk) begin
    if (wr_en) begin
        for (int b = 0; b < STRB_W; b++) begin
            if (head.strb[b]) begin
                mem[word_idx][8*b +: 8] <= head.wdata[8*b +: 8];
            end
        end
    end
end

// response payload, captured at the pop edge
always_ff @(posedge clk) begin
    if (pop) begin
        rsp.err <= head.bad;
        if (rd_en) begin
            rsp.rdata <= mem[word_idx];
        end
        else begin
            rsp.rdata <= '0;
        end
    end
end

// valid holds while the consumer stalls
always_ff @(posedge clk) begin
    if (reset) begin
        rsp_valid <= 1'b0;
    end
    else if (pop) begin
        rsp_valid <= 1'b1;
    end
    else if (rsp_ready) begin
        rsp_valid <= 1'b0;
    end
end

// one credit per entry leaving the queue
always_ff @(posedge clk) begin
    if (reset) begin
        credit_return <= 1'b0;
    end
    else begin
        credit_return <= pop;
    end
end

endmodule

// ==== source/mem_subsys.sv ====
`timescale 1ns/1ns

module mem_subsys (
    input  logic               clk,
    input  logic               reset,

    // request port
    input  logic               req_valid,
    input  mem_pkg::mem_req_t  req,
    output logic               req_ready,

    // response port
    output logic               rsp_valid,
    output mem_pkg::mem_rsp_t  rsp,
    input  logic               rsp_ready
);

logic               push;
mem_pkg::mem_req_t  push_req;
logic               not_empty;
mem_pkg::mem_req_t  head;
logic               pop;
logic               credit_return;

mem_req_port u_mem_req_port (
    .clk           ( clk           ),
    .reset         ( reset         ),
    .req_valid     ( req_valid     ),
    .req           ( req           ),
    .req_ready     ( req_ready     ),
    .push          ( push          ),
    .push_req      ( push_req      ),
    .credit_return ( credit_return )
);

mem_req_queue u_mem_req_queue (
    .clk           ( clk           ),
    .reset         ( reset         ),
    .push          ( push          ),
    .push_req      ( push_req      ),
    .pop           ( pop           ),
    .not_empty     ( not_empty     ),
    .head          ( head          )
);

sram_bank u_sram_bank (
    .clk           ( clk           ),
    .reset         ( reset         ),
    .not_empty     ( not_empty     ),
    .head          ( head          ),
    .pop           ( pop           ),
    .credit_return ( credit_return ),
    .rsp_valid     ( rsp_valid     ),
    .rsp           ( rsp           ),
    .rsp_ready     ( rsp_ready     )
);

endmodule

// ==== verification/mem_subsys_tb.sv ====
`timescale 1ns/1ns
`include "mem_settings.svh"

module mem_subsys_tb;

localparam int ACCEPT_TIMEOUT = 200;
localparam int RSP_TIMEOUT    = 200;
localparam int DRAIN_TIMEOUT  = 200;
localparam int RUN_TIMEOUT    = 20000;
localparam int STALL_LIMIT    = `REQ_QUEUE_DEPTH + 1;

logic               clk;
logic               reset;
logic               req_valid;
mem_pkg::mem_req_t  req;
logic               req_ready;
logic               rsp_valid;
mem_pkg::mem_rsp_t  rsp;
logic               rsp_ready;

// requests and expected responses in file order
mem_pkg::mem_req_t  req_list [$];
mem_pkg::mem_rsp_t  exp_list [$];
int                 stall_list [$];
// responses still owed by the DUT
mem_pkg::mem_rsp_t  exp_q [$];

logic [31:0] lfsr_state;
int          errors;
int          timeouts;

mem_subsys mem_subsys_inst (
    .clk       ( clk       ),
    .reset     ( reset     ),
    .req_valid ( req_valid ),
    .req       ( req       ),
    .req_ready ( req_ready ),
    .rsp_valid ( rsp_valid ),
    .rsp       ( rsp       ),
    .rsp_ready ( rsp_ready )
);

always #5 clk = ~clk;

function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] stepped;
    stepped = state >> 1;
    if (state[0]) begin
        stepped = stepped ^ 32'h8020_0003;
    end
    return stepped;
endfunction

task automatic take_bit(output logic bit_out);
    lfsr_state = lfsr_step(lfsr_state);
    bit_out    = lfsr_state[0];
endtask

task automatic check_rsp(input mem_pkg::mem_rsp_t expected, input mem_pkg::mem_rsp_t actual);
    if (actual !== expected) begin
        errors++;
        $display("CHECK FAILED at %0t: rsp expected rdata=%h err=%0b, actual rdata=%h err=%0b",
                 $time, expected.rdata, expected.err, actual.rdata, actual.err);
    end
endtask

task automatic check_ready(input logic expected, input logic actual);
    if (actual !== expected) begin
        errors++;
        $display("CHECK FAILED at %0t: req_ready expected %0b, actual %0b",
                 $time, expected, actual);
    end
endtask

task automatic check_valid(input logic expected, input logic actual);
    if (actual !== expected) begin
        errors++;
        $display("CHECK FAILED at %0t: rsp_valid expected %0b, actual %0b",
                 $time, expected, actual);
    end
endtask

task automatic check_accept_limit(input int limit, input int actual);
    if (actual > limit) begin
        errors++;
        $display("CHECK FAILED at %0t: stall_accepts expected at most %0d, actual %0d",
                 $time, limit, actual);
    end
endtask

task automatic load_patterns(output bit ok);
    int                           fd;
    int                           code;
    int                           cycles;
    int                           stall_next;
    string                        line;
    logic [7:0]                   op;
    logic [`MEM_ADDR_WIDTH-1:0]   addr;
    logic [`MEM_DATA_WIDTH/8-1:0] strb;
    logic [`MEM_DATA_WIDTH-1:0]   wdata;
    logic [`MEM_DATA_WIDTH-1:0]   rdata;
    logic                         err;
    mem_pkg::mem_req_t            r;
    mem_pkg::mem_rsp_t            e;
    ok         = 1'b0;
    stall_next = 0;
    fd = $fopen("verification/mem_patterns.txt", "r");
    if (fd == 0) begin
        errors++;
        $display("cannot open the pattern file verification/mem_patterns.txt");
        return;
    end
    while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
            continue;
        end
        op = line.getc(0);
        if (op == "S") begin
            code = $sscanf(line.substr(1, line.len() - 1), "%d", cycles);
            if (code != 1 || cycles <= 0) begin
                errors++;
                $display("bad stall line in pattern file: %s", line);
            end
            else begin
                stall_next = cycles;
            end
            continue;
        end
        code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                       addr, strb, wdata, rdata, err);
        if (code != 5 || (op != "W" && op != "R")) begin
            errors++;
            $display("malformed line in pattern file: %s", line);
            continue;
        end
        // bad stays zero for the producer to decide
        r       = '0;
        r.addr  = addr;
        r.write = (op == "W");
        r.strb  = strb;
        r.wdata = wdata;
        e.rdata = rdata;
        e.err   = err;
        req_list.push_back(r);
        exp_list.push_back(e);
        stall_list.push_back(stall_next);
        stall_next = 0;
    end
    $fclose(fd);
    if (req_list.size() == 0) begin
        errors++;
        $display("the pattern file holds no requests");
        return;
    end
    ok = 1'b1;
endtask

initial begin
    bit                loaded;
    bit                done;
    bit                offering;
    bit                stalling;
    logic              gap_bit;
    logic              hold_a;
    logic              hold_b;
    logic              ready_seen;
    logic              valid_seen;
    mem_pkg::mem_rsp_t rsp_seen;
    int                idx;
    int                cycle;
    int                accept_wait;
    int                rsp_wait;
    int                drain_wait;
    int                stall_left;
    int                stall_accepts;

    clk        = 1'b0;
    reset      = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    rsp_ready  = 1'b0;
    lfsr_state = 32'hfd747146;
    errors     = 0;
    timeouts   = 0;
    offering   = 1'b0;
    stalling   = 1'b0;
    idx           = 0;
    cycle         = 0;
    accept_wait   = 0;
    rsp_wait      = 0;
    drain_wait    = 0;
    stall_left    = 0;
    stall_accepts = 0;

    load_patterns(loaded);

    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // idle right after reset
    @(negedge clk);
    check_ready(1'b1, req_ready);
    check_valid(1'b0, rsp_valid);

    done = !loaded;
    while (!done) begin
        @(negedge clk);
        if (!offering && idx < req_list.size()) begin
            if (stall_list[idx] > 0) begin
                // stall segment starts from an empty pipeline
                if (exp_q.size() == 0) begin
                    stall_left      = stall_list[idx];
                    stall_list[idx] = 0;
                    stall_accepts   = 0;
                    drain_wait      = 0;
                    offering        = 1'b1;
                end
            end
            else if (stall_left > 0) begin
                offering = 1'b1;
            end
            else begin
                take_bit(gap_bit);
                offering = gap_bit;
            end
        end
        req_valid = offering;
        if (offering) begin
            req = req_list[idx];
        end
        if (stall_left > 0) begin
            rsp_ready  = 1'b0;
            stalling   = 1'b1;
            stall_left = stall_left - 1;
        end
        else begin
            // ready about three cycles in four
            stalling = 1'b0;
            take_bit(hold_a);
            take_bit(hold_b);
            rsp_ready = !(hold_a && hold_b);
        end

        // registered outputs, settled since the last rising edge
        ready_seen = req_ready;
        valid_seen = rsp_valid;
        rsp_seen   = rsp;

        @(posedge clk);
        cycle++;
        if (req_valid && ready_seen) begin
            exp_q.push_back(exp_list[idx]);
            idx++;
            offering    = 1'b0;
            accept_wait = 0;
            if (stalling) begin
                stall_accepts++;
            end
        end
        else if (req_valid) begin
            accept_wait++;
            if (accept_wait > ACCEPT_TIMEOUT) begin
                timeouts++;
                done = 1'b1;
                $display("timeout: request %0d not accepted within %0d cycles",
                         idx, ACCEPT_TIMEOUT);
            end
        end
        if (valid_seen && rsp_ready) begin
            rsp_wait = 0;
            if (exp_q.size() == 0) begin
                errors++;
                $display("a response arrived at %0t with no request outstanding", $time);
            end
            else begin
                check_rsp(exp_q.pop_front(), rsp_seen);
            end
        end
        else if (exp_q.size() > 0) begin
            rsp_wait++;
            if (rsp_wait > RSP_TIMEOUT) begin
                timeouts++;
                done = 1'b1;
                $display("timeout: no response within %0d cycles", RSP_TIMEOUT);
            end
        end
        // queue and response slot full by the last held cycle
        if (stalling && stall_left == 0) begin
            check_accept_limit(STALL_LIMIT, stall_accepts);
            check_ready(1'b0, ready_seen);
        end
        if (!offering && idx < req_list.size() && stall_list[idx] > 0) begin
            drain_wait++;
            if (drain_wait > DRAIN_TIMEOUT) begin
                timeouts++;
                done = 1'b1;
                $display("timeout: responses did not drain before the stall segment");
            end
        end
        if (idx == req_list.size() && exp_q.size() == 0) begin
            done = 1'b1;
        end
        if (cycle > RUN_TIMEOUT) begin
            timeouts++;
            done = 1'b1;
            $display("timeout: run exceeded %0d cycles", RUN_TIMEOUT);
        end
    end

    $display("summary: %0d errors, %0d timeouts, %0d of %0d requests issued",
             errors, timeouts, idx, req_list.size());
    if (errors == 0 && timeouts == 0) begin
        $display("Regression passed");
    end
    else begin
        $display("Regression failed");
    end
    $finish;
end

endmodule

// ==== verification/mem_patterns.txt ====
# op addr strb wdata exp_rdata exp_err; op is W or R, other columns in hex
# a line S n (n decimal) holds rsp_ready low for n cycles once all responses are in
# full word writes and reads
W 00010000 f 11223344 00000000 0
R 00010000 0 00000000 11223344 0
W 00010004 f a5a5a5a5 00000000 0
W 00010ffc f deadbeef 00000000 0
R 00010004 0 00000000 a5a5a5a5 0
R 00010ffc 0 00000000 deadbeef 0
W 00010008 f cafef00d 00000000 0
R 00010008 0 00000000 cafef00d 0
R 00010000 0 00000000 11223344 0
# partial strobes merge into the stored word
W 00010010 f 01234567 00000000 0
W 00010010 1 ffffffaa 00000000 0
R 00010010 0 00000000 012345aa 0
W 00010010 c 99887766 00000000 0
R 00010010 0 00000000 998845aa 0
W 00010010 6 00bbcc00 00000000 0
R 00010010 0 00000000 99bbccaa 0
W 00010014 f 55667788 00000000 0
W 00010014 0 ffffffff 00000000 0
R 00010014 0 00000000 55667788 0
W 00010018 f 00000000 00000000 0
W 00010018 8 12ffffff 00000000 0
R 00010018 0 00000000 12000000 0
# out of window or unaligned, some alias onto written words
R 00020000 0 00000000 00000000 1
R 0000fffc 0 00000000 00000000 1
W 00011000 f 0badf00d 00000000 1
W 00010002 f ffffffff 00000000 1
W 00030004 f 0badcafe 00000000 1
R 00010ffe 0 00000000 00000000 1
R 00000000 0 00000000 00000000 1
W ffff0000 f 0bad0bad 00000000 1
R 00010001 0 00000000 00000000 1
# array untouched by the failed writes
R 00010000 0 00000000 11223344 0
R 00010004 0 00000000 a5a5a5a5 0
R 00010ffc 0 00000000 deadbeef 0
# responses held off while requests are offered every cycle
S 20
W 00010100 f 00000001 00000000 0
W 00010104 f 00000002 00000000 0
R 00010100 0 00000000 00000001 0
W 00010108 f 00000003 00000000 0
R 00010104 0 00000000 00000002 0
R 00020000 0 00000000 00000000 1
W 00010100 3 0000ffee 00000000 0
R 00010100 0 00000000 0000ffee 0
R 00010108 0 00000000 00000003 0
# mixed traffic with random gaps and back-pressure
W 00010200 f 89abcdef 00000000 0
W 00010204 f 76543210 00000000 0
R 00010200 0 00000000 89abcdef 0
W 00010200 2 0000aa00 00000000 0
R 00010200 0 00000000 89abaaef 0
R 00010204 0 00000000 76543210 0
W 00010204 9 11000022 00000000 0
R 00010204 0 00000000 11543222 0
W 00012000 f 00000000 00000000 1
R 00010204 0 00000000 11543222 0
R 00010010 0 00000000 99bbccaa 0
R 00010018 0 00000000 12000000 0
W 00010ffc 4 00770000 00000000 0
R 00010ffc 0 00000000 de77beef 0

// ==== compile.f ====
+incdir+source
source/mem_pkg.sv
source/mem_req_port.sv
source/mem_req_queue.sv
source/sram_bank.sv
source/mem_subsys.sv
verification/mem_subsys_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the mem_subsys testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG" build.log

verilator --binary --timing -f compile.f --top-module mem_subsys_tb \
        -o mem_subsys_sim > build.log 2>&1 \
    && ./obj_dir/mem_subsys_sim > "$LOG" 2>&1 \
    || { cat build.log; echo "build or simulation error"; }

cat "$LOG" 2>/dev/null
grep -qx "Regression passed" "$LOG" 2>/dev/null && exit 0 || exit 1
